/* logic/mem_bus_pkg.sv */
/*
 * Memory bus definitions
 * Widths, sink size, back-pressure pattern and the plain vector types
 * shared by the split read/write channels and the shared command bus
 */
package mem_bus_pkg;

    // Word address, so the sink holds 2**addr_width words
    localparam int addr_width = 8;
    localparam int mem_words = 2 ** addr_width;

    localparam int data_width = 32;
    localparam int be_width = data_width / 8;

    // Bursts are 1 to 4 beats
    localparam int burst_width = 3;

    localparam int user_width = 4;

    // Sink raises waitrequest in one cycle out of every wait_period
    localparam int wait_period = 4;

    typedef logic [addr_width-1:0] mem_addr_t;
    typedef logic [data_width-1:0] mem_data_t;
    typedef logic [be_width-1:0] mem_be_t;
    typedef logic [burst_width-1:0] mem_burst_t;
    typedef logic [user_width-1:0] mem_user_t;

endpackage

/* logic/mem_msg_pkg.sv */
/*
 * Memory message definitions
 * Request, command and response structs carried between the source,
 * the request queues, the arbiter and the memory sink
 */
package mem_msg_pkg;

    // Read request channel
    typedef struct packed {
        mem_bus_pkg::mem_addr_t address;
        mem_bus_pkg::mem_burst_t burstcount;
        mem_bus_pkg::mem_be_t byteenable;
        mem_bus_pkg::mem_user_t user;
    } rd_req_t;

    // Write request channel, one beat per transfer
    typedef struct packed {
        mem_bus_pkg::mem_addr_t address;
        mem_bus_pkg::mem_burst_t burstcount;
        mem_bus_pkg::mem_data_t data;
        mem_bus_pkg::mem_be_t byteenable;
        mem_bus_pkg::mem_user_t user;
        logic eop;
    } wr_req_t;

    // Shared bus command
    typedef struct packed {
        logic read;
        logic write;
        mem_bus_pkg::mem_addr_t address;
        mem_bus_pkg::mem_burst_t burstcount;
        mem_bus_pkg::mem_data_t writedata;
        mem_bus_pkg::mem_be_t byteenable;
        mem_bus_pkg::mem_user_t user;
    } mem_cmd_t;

    typedef struct packed {
        mem_bus_pkg::mem_data_t readdata;
        mem_bus_pkg::mem_user_t user;
    } rd_rsp_t;

    typedef struct packed {
        mem_bus_pkg::mem_user_t user;
    } wr_rsp_t;

endpackage

/* logic/rdwr_req_queue.sv */
`timescale 1ns/1ps
/*
 * Read/write request queues
 * Two-entry queues on the read and write channels. Write beats are
 * counted so the stored last beat of each burst carries eop
 */
module rdwr_req_queue
(
    input  logic                  clk,
    input  logic                  reset_n,
    input  logic                  rd_valid,
    input  mem_msg_pkg::rd_req_t  rd_req,
    input  logic                  wr_valid,
    input  mem_msg_pkg::wr_req_t  wr_req,
    input  logic                  rd_pop,
    input  logic                  wr_pop,
    output logic                  rd_waitrequest,
    output logic                  wr_waitrequest,
    output mem_msg_pkg::rd_req_t  rd_head,
    output logic                  rd_ready,
    output mem_msg_pkg::wr_req_t  wr_head,
    output logic                  wr_ready
);

    mem_msg_pkg::rd_req_t rd_q [2];
    logic [1:0] rd_count;
    logic rd_push;

    mem_msg_pkg::wr_req_t wr_q [2];
    logic [1:0] wr_count;
    logic wr_push;
    mem_msg_pkg::wr_req_t wr_in;

    // Beats still expected in the current source burst, zero between bursts
    mem_bus_pkg::mem_burst_t wr_beats_left;

    // Full at two entries
    assign rd_waitrequest = rd_count[1];
    assign wr_waitrequest = wr_count[1];

    assign rd_push = rd_valid && !rd_waitrequest;
    assign wr_push = wr_valid && !wr_waitrequest;

    assign rd_head = rd_q[0];
    assign wr_head = wr_q[0];
    assign rd_ready = (rd_count != 2'd0);
    assign wr_ready = (wr_count != 2'd0);

    // Mark the last beat from the burst count of the first beat
    always_comb
    begin
        wr_in = wr_req;
        if (wr_beats_left == '0)
            wr_in.eop = (wr_req.burstcount == mem_bus_pkg::mem_burst_t'(1));
        else
            wr_in.eop = (wr_beats_left == mem_bus_pkg::mem_burst_t'(1));
    end

    always_ff @(posedge clk)
    begin
        if (!reset_n)
        begin
            rd_count <= 2'd0;
            wr_count <= 2'd0;
            wr_beats_left <= '0;
        end
        else
        begin
            rd_count <= rd_count + 2'(rd_push) - 2'(rd_pop);
            wr_count <= wr_count + 2'(wr_push) - 2'(wr_pop);
            if (wr_push)
            begin
                if (wr_beats_left == '0)
                    wr_beats_left <= wr_req.burstcount - 1'b1;
                else
                    wr_beats_left <= wr_beats_left - 1'b1;
            end
        end
    end

    // Entry 0 is the head; a push lands in the first free slot after the pop
    always_ff @(posedge clk)
    begin
        if (rd_pop)
            rd_q[0] <= rd_q[1];
        if (rd_push)
        begin
            if (rd_count == 2'd0 || (rd_count == 2'd1 && rd_pop))
                rd_q[0] <= rd_req;
            else
                rd_q[1] <= rd_req;
        end

        if (wr_pop)
            wr_q[0] <= wr_q[1];
        if (wr_push)
        begin
            if (wr_count == 2'd0 || (wr_count == 2'd1 && wr_pop))
                wr_q[0] <= wr_in;
            else
                wr_q[1] <= wr_in;
        end
    end

endmodule

/* logic/rdwr_arbiter.sv */
`timescale 1ns/1ps
/*
 * Read/write arbiter
 * Round-robin between the read and write queue heads, locked onto an
 * open write burst, steering the winner onto the shared command bus.
 * Write responses come from the sink or are generated locally
 */
module rdwr_arbiter
#(
    parameter bit local_wr_response = 1'b0
)
(
    input  logic                   clk,
    input  logic                   reset_n,
    input  mem_msg_pkg::rd_req_t   rd_head,
    input  logic                   rd_ready,
    input  mem_msg_pkg::wr_req_t   wr_head,
    input  logic                   wr_ready,
    input  logic                   cmd_waitrequest,
    input  logic                   sink_wr_rsp_valid,
    input  mem_msg_pkg::wr_rsp_t   sink_wr_rsp,
    output logic                   rd_pop,
    output logic                   wr_pop,
    output mem_msg_pkg::mem_cmd_t  cmd,
    output logic                   wr_rsp_valid,
    output mem_msg_pkg::wr_rsp_t   wr_rsp
);

    logic wr_burst_open;
    logic prefer_write;
    logic held;
    logic held_write;
    logic pick_write;
    logic grant_rd;
    logic grant_wr;
    logic accept;

    // A command offered under waitrequest keeps its side until accepted
    always_comb
    begin
        if (wr_burst_open)
            pick_write = 1'b1;
        else if (held)
            pick_write = held_write;
        else if (rd_ready && wr_ready)
            pick_write = prefer_write;
        else
            pick_write = wr_ready;
    end

    assign grant_wr = pick_write && wr_ready;
    assign grant_rd = !pick_write && rd_ready;

    assign accept = (grant_rd || grant_wr) && !cmd_waitrequest;
    assign rd_pop = grant_rd && !cmd_waitrequest;
    assign wr_pop = grant_wr && !cmd_waitrequest;

    always_comb
    begin
        cmd.read = grant_rd;
        cmd.write = grant_wr;
        cmd.address = grant_rd ? rd_head.address : wr_head.address;
        cmd.burstcount = grant_rd ? rd_head.burstcount : wr_head.burstcount;
        cmd.writedata = wr_head.data;
        cmd.byteenable = grant_rd ? rd_head.byteenable : wr_head.byteenable;
        cmd.user = grant_rd ? rd_head.user : wr_head.user;
    end

    always_ff @(posedge clk)
    begin
        if (!reset_n)
        begin
            wr_burst_open <= 1'b0;
            prefer_write <= 1'b0;
            held <= 1'b0;
            held_write <= 1'b0;
        end
        else
        begin
            held <= (grant_rd || grant_wr) && cmd_waitrequest;
            held_write <= grant_wr;
            if (accept)
            begin
                // Only a new request flips priority, not a later burst beat
                if (!wr_burst_open)
                    prefer_write <= grant_rd;
                wr_burst_open <= grant_wr && !wr_head.eop;
            end
        end
    end

    always_ff @(posedge clk)
    begin
        if (!reset_n)
            wr_rsp_valid <= 1'b0;
        else if (local_wr_response)
            wr_rsp_valid <= wr_pop && wr_head.eop;
        else
            wr_rsp_valid <= sink_wr_rsp_valid;
    end

    always_ff @(posedge clk)
    begin
        if (local_wr_response)
        begin
            // User tag of the burst is taken from its first beat
            if (wr_pop && !wr_burst_open)
                wr_rsp.user <= wr_head.user;
        end
        else
        begin
            wr_rsp <= sink_wr_rsp;
        end
    end

endmodule

/* logic/mem_sink_model.sv */
`timescale 1ns/1ps
/*
 * Memory sink model
 * Word memory behind the shared command bus with periodic back-pressure,
 * streamed read bursts and one write response per write burst
 */
module mem_sink_model
(
    input  logic                   clk,
    input  logic                   reset_n,
    input  mem_msg_pkg::mem_cmd_t  cmd,
    output logic                   cmd_waitrequest,
    output logic                   rd_rsp_valid,
    output mem_msg_pkg::rd_rsp_t   rd_rsp,
    output logic                   wr_rsp_valid,
    output mem_msg_pkg::wr_rsp_t   wr_rsp
);

    typedef enum logic {idle, read_burst} sink_state_t;

    mem_bus_pkg::mem_data_t mem [mem_bus_pkg::mem_words];
    logic [$clog2(mem_bus_pkg::wait_period)-1:0] wait_cnt;
    sink_state_t state;

    mem_bus_pkg::mem_addr_t rd_addr;
    mem_bus_pkg::mem_burst_t rd_left;
    mem_bus_pkg::mem_user_t rd_user;

    // Beat index inside the current write burst
    mem_bus_pkg::mem_burst_t wr_beat;
    mem_bus_pkg::mem_addr_t wr_addr;
    mem_bus_pkg::mem_data_t wr_merged;

    logic busy_slot;
    logic rd_accept;
    logic wr_accept;
    logic wr_last;

    assign busy_slot = (int'(wait_cnt) == mem_bus_pkg::wait_period - 1);
    assign cmd_waitrequest = busy_slot || (state == read_burst);

    assign rd_accept = cmd.read && !cmd_waitrequest;
    assign wr_accept = cmd.write && !cmd_waitrequest;
    assign wr_last = (wr_beat == cmd.burstcount - 1'b1);
    assign wr_addr = cmd.address + mem_bus_pkg::mem_addr_t'(wr_beat);

    // Read beats stream straight from the array
    assign rd_rsp_valid = (state == read_burst);
    assign rd_rsp.readdata = mem[rd_addr];
    assign rd_rsp.user = rd_user;

    // Byte lane merge into the old word
    always_comb
    begin
        wr_merged = mem[wr_addr];
        for (int i = 0; i < mem_bus_pkg::be_width; i++)
        begin
            if (cmd.byteenable[i])
                wr_merged[8*i +: 8] = cmd.writedata[8*i +: 8];
        end
    end

    always_ff @(posedge clk)
    begin
        if (!reset_n)
        begin
            state <= idle;
            wait_cnt <= '0;
            wr_beat <= '0;
            wr_rsp_valid <= 1'b0;
        end
        else
        begin
            wait_cnt <= busy_slot ? '0 : wait_cnt + 1'b1;
            wr_rsp_valid <= wr_accept && wr_last;
            if (wr_accept)
                wr_beat <= wr_last ? '0 : wr_beat + 1'b1;

            case (state)
                idle:
                    if (rd_accept)
                        state <= read_burst;
                read_burst:
                    if (rd_left == mem_bus_pkg::mem_burst_t'(1))
                        state <= idle;
                default:
                    state <= idle;
            endcase
        end
    end

    always_ff @(posedge clk)
    begin
        if (rd_accept)
        begin
            rd_addr <= cmd.address;
            rd_left <= cmd.burstcount;
            rd_user <= cmd.user;
        end
        else if (state == read_burst)
        begin
            rd_addr <= rd_addr + 1'b1;
            rd_left <= rd_left - 1'b1;
        end

        if (wr_accept)
            mem[wr_addr] <= wr_merged;
        if (wr_accept && wr_last)
            wr_rsp.user <= cmd.user;
    end

endmodule

/* logic/rdwr_mem_top.sv */
`timescale 1ns/1ps
/*
 * Split read/write source to shared memory bus
 * Request queues, read/write arbiter and memory sink model
 */
module rdwr_mem_top
#(
    parameter bit local_wr_response = 1'b0
)
(
    input  logic                  clk,
    input  logic                  reset_n,
    input  logic                  rd_valid,
    input  mem_msg_pkg::rd_req_t  rd_req,
    output logic                  rd_waitrequest,
    input  logic                  wr_valid,
    input  mem_msg_pkg::wr_req_t  wr_req,
    output logic                  wr_waitrequest,
    output logic                  rd_rsp_valid,
    output mem_msg_pkg::rd_rsp_t  rd_rsp,
    output logic                  wr_rsp_valid,
    output mem_msg_pkg::wr_rsp_t  wr_rsp
);

    mem_msg_pkg::rd_req_t rd_head;
    mem_msg_pkg::wr_req_t wr_head;
    logic rd_ready;
    logic wr_ready;
    logic rd_pop;
    logic wr_pop;
    mem_msg_pkg::mem_cmd_t cmd;
    logic cmd_waitrequest;
    logic sink_wr_rsp_valid;
    mem_msg_pkg::wr_rsp_t sink_wr_rsp;

    rdwr_req_queue queue
    (
        .clk(clk),
        .reset_n(reset_n),
        .rd_valid(rd_valid),
        .rd_req(rd_req),
        .wr_valid(wr_valid),
        .wr_req(wr_req),
        .rd_pop(rd_pop),
        .wr_pop(wr_pop),
        .rd_waitrequest(rd_waitrequest),
        .wr_waitrequest(wr_waitrequest),
        .rd_head(rd_head),
        .rd_ready(rd_ready),
        .wr_head(wr_head),
        .wr_ready(wr_ready)
    );

    rdwr_arbiter #(.local_wr_response(local_wr_response)) arbiter
    (
        .clk(clk),
        .reset_n(reset_n),
        .rd_head(rd_head),
        .rd_ready(rd_ready),
        .wr_head(wr_head),
        .wr_ready(wr_ready),
        .cmd_waitrequest(cmd_waitrequest),
        .sink_wr_rsp_valid(sink_wr_rsp_valid),
        .sink_wr_rsp(sink_wr_rsp),
        .rd_pop(rd_pop),
        .wr_pop(wr_pop),
        .cmd(cmd),
        .wr_rsp_valid(wr_rsp_valid),
        .wr_rsp(wr_rsp)
    );

    // Read data goes straight back to the source
    mem_sink_model sink
    (
        .clk(clk),
        .reset_n(reset_n),
        .cmd(cmd),
        .cmd_waitrequest(cmd_waitrequest),
        .rd_rsp_valid(rd_rsp_valid),
        .rd_rsp(rd_rsp),
        .wr_rsp_valid(sink_wr_rsp_valid),
        .wr_rsp(sink_wr_rsp)
    );

endmodule

/* test/rdwr_mem_chk.sv */
`timescale 1ns/1ps
/*
 * Shared command bus checker
 * Burst contiguity, command hold under waitrequest and reset state
 */
module rdwr_mem_chk
(
    input logic                  clk,
    input logic                  reset_n,
    input mem_msg_pkg::mem_cmd_t cmd,
    input logic                  cmd_waitrequest,
    input logic                  rd_rsp_valid,
    input logic                  wr_rsp_valid
);

    int fail_count;
    logic wr_accept;

    // Beats left in the write burst on the bus, zero between bursts
    mem_bus_pkg::mem_burst_t wr_left;

    initial fail_count = 0;

    assign wr_accept = cmd.write && !cmd_waitrequest;

    always_ff @(posedge clk)
    begin
        if (!reset_n)
            wr_left <= '0;
        else if (wr_accept)
            wr_left <= (wr_left == '0) ? cmd.burstcount - 1'b1 : wr_left - 1'b1;
    end

    read_in_burst: assert property (@(posedge clk) disable iff (!reset_n)
        (wr_left != '0) |-> !cmd.read)
        else
        begin
            $error("read command issued inside an open write burst");
            fail_count++;
        end

    cmd_held: assert property (@(posedge clk) disable iff (!reset_n)
        ((cmd.read || cmd.write) && cmd_waitrequest) |=>
        $stable({cmd.read, cmd.write, cmd.address, cmd.burstcount, cmd.byteenable, cmd.user}))
        else
        begin
            $error("command changed while held under waitrequest");
            fail_count++;
        end

    rsp_after_reset: assert property (@(posedge clk)
        !reset_n |=> (!rd_rsp_valid && !wr_rsp_valid))
        else
        begin
            $error("response valid high after reset");
            fail_count++;
        end

endmodule

bind rdwr_mem_top rdwr_mem_chk chk
(
    .clk(clk),
    .reset_n(reset_n),
    .cmd(cmd),
    .cmd_waitrequest(cmd_waitrequest),
    .rd_rsp_valid(rd_rsp_valid),
    .wr_rsp_valid(wr_rsp_valid)
);

/* test/rdwr_mem_tb.sv */
`timescale 1ns/1ps
/*
 * Testbench for the split read/write memory bridge
 * Table-driven reads and writes checked against a shadow memory
 */
module rdwr_mem_tb;

    typedef struct packed {
        logic is_write;
        mem_bus_pkg::mem_addr_t addr;
        mem_bus_pkg::mem_burst_t len;
        mem_bus_pkg::mem_user_t user;
        logic partial;
        logic with_next;
    } op_t;

    localparam int num_ops = 19;
    localparam int wait_limit = 200;

    // Columns: is_write, address, burst length, user, partial byteenable, issue with next
    localparam op_t ops [num_ops] = '{
        '{1'b1, 8'h10, 3'd1, 4'h1, 1'b0, 1'b0},
        '{1'b1, 8'h20, 3'd4, 4'h2, 1'b0, 1'b0},
        '{1'b0, 8'h10, 3'd1, 4'h3, 1'b0, 1'b0},
        '{1'b0, 8'h20, 3'd4, 4'h4, 1'b0, 1'b0},
        '{1'b1, 8'h20, 3'd4, 4'h5, 1'b1, 1'b0},
        '{1'b0, 8'h20, 3'd4, 4'h6, 1'b0, 1'b0},
        '{1'b1, 8'h40, 3'd4, 4'h7, 1'b0, 1'b1},
        '{1'b0, 8'h20, 3'd2, 4'h8, 1'b0, 1'b1},
        '{1'b1, 8'h60, 3'd2, 4'h9, 1'b0, 1'b1},
        '{1'b0, 8'h10, 3'd1, 4'ha, 1'b0, 1'b0},
        '{1'b1, 8'h80, 3'd1, 4'hb, 1'b0, 1'b1},
        '{1'b1, 8'h81, 3'd1, 4'hc, 1'b0, 1'b1},
        '{1'b1, 8'h82, 3'd3, 4'hd, 1'b0, 1'b0},
        '{1'b0, 8'h40, 3'd4, 4'he, 1'b0, 1'b1},
        '{1'b0, 8'h60, 3'd2, 4'hf, 1'b0, 1'b1},
        '{1'b0, 8'h80, 3'd4, 4'h0, 1'b0, 1'b1},
        '{1'b0, 8'h20, 3'd4, 4'h1, 1'b0, 1'b0},
        '{1'b1, 8'h10, 3'd1, 4'h2, 1'b1, 1'b0},
        '{1'b0, 8'h10, 3'd1, 4'h3, 1'b0, 1'b0}
    };

    logic clk;
    logic reset_n;
    logic rd_valid;
    mem_msg_pkg::rd_req_t rd_req;
    logic rd_waitrequest;
    logic wr_valid;
    mem_msg_pkg::wr_req_t wr_req;
    logic wr_waitrequest;
    logic rd_rsp_valid;
    mem_msg_pkg::rd_rsp_t rd_rsp;
    logic wr_rsp_valid;
    mem_msg_pkg::wr_rsp_t wr_rsp;

    mem_bus_pkg::mem_data_t shadow [mem_bus_pkg::mem_words];
    mem_msg_pkg::rd_rsp_t exp_rd [$];
    mem_msg_pkg::wr_rsp_t exp_wr [$];
    int value_errors;
    int timeout_errors;
    int rd_beats_seen;
    int wr_rsps_seen;
    int exp_rd_total;
    int exp_wr_total;
    int rd_stall_cycles;
    int first;
    int idx;

    rdwr_mem_top #(.local_wr_response(1'b1)) uut
    (
        .clk(clk),
        .reset_n(reset_n),
        .rd_valid(rd_valid),
        .rd_req(rd_req),
        .rd_waitrequest(rd_waitrequest),
        .wr_valid(wr_valid),
        .wr_req(wr_req),
        .wr_waitrequest(wr_waitrequest),
        .rd_rsp_valid(rd_rsp_valid),
        .rd_rsp(rd_rsp),
        .wr_rsp_valid(wr_rsp_valid),
        .wr_rsp(wr_rsp)
    );

    initial
    begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    task automatic check_rd_rsp(input mem_msg_pkg::rd_rsp_t got, input mem_msg_pkg::rd_rsp_t exp);
        if (got !== exp)
        begin
            value_errors++;
            $display("ERROR rd_rsp: readdata %h user %h, expected readdata %h user %h",
                     got.readdata, got.user, exp.readdata, exp.user);
        end
    endtask

    task automatic check_wr_rsp(input mem_msg_pkg::wr_rsp_t got, input mem_msg_pkg::wr_rsp_t exp);
        if (got !== exp)
        begin
            value_errors++;
            $display("ERROR wr_rsp: user %h, expected user %h", got.user, exp.user);
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp)
        begin
            value_errors++;
            $display("ERROR %s: got %h expected %h", name, got, exp);
        end
    endtask

    task automatic check_count(input string name, input int got, input int exp);
        if (got != exp)
        begin
            value_errors++;
            $display("ERROR %s: got %h expected %h", name, got, exp);
        end
    endtask

    // Responses are sampled mid-cycle, away from the clock edge
    always @(negedge clk)
    begin
        if (reset_n && rd_rsp_valid)
        begin
            rd_beats_seen++;
            if (exp_rd.size() == 0)
            begin
                value_errors++;
                $display("A read beat arrived with no read outstanding");
            end
            else
                check_rd_rsp(rd_rsp, exp_rd.pop_front());
        end
        if (reset_n && wr_rsp_valid)
        begin
            wr_rsps_seen++;
            if (exp_wr.size() == 0)
            begin
                value_errors++;
                $display("A write response arrived with no write burst outstanding");
            end
            else
                check_wr_rsp(wr_rsp, exp_wr.pop_front());
        end
    end

    task automatic issue_read(input op_t op);
        mem_msg_pkg::rd_rsp_t e;
        int b;
        int t;
        for (b = 0; b < int'(op.len); b++)
        begin
            e.readdata = shadow[mem_bus_pkg::mem_addr_t'(op.addr + b)];
            e.user = op.user;
            exp_rd.push_back(e);
        end
        rd_valid = 1'b1;
        rd_req.address = op.addr;
        rd_req.burstcount = op.len;
        rd_req.byteenable = '1;
        rd_req.user = op.user;
        t = 0;
        while (rd_waitrequest && t < wait_limit)
        begin
            rd_stall_cycles++;
            @(posedge clk);
            #1;
            t++;
        end
        if (rd_waitrequest)
        begin
            timeout_errors++;
            $display("Read request at address %h was never accepted", op.addr);
        end
        else
        begin
            @(posedge clk);
            #1;
        end
        rd_valid = 1'b0;
    endtask

    task automatic issue_write(input op_t op);
        mem_msg_pkg::wr_rsp_t w;
        mem_bus_pkg::mem_data_t d;
        mem_bus_pkg::mem_be_t be;
        mem_bus_pkg::mem_addr_t a;
        int b;
        int t;
        w.user = op.user;
        exp_wr.push_back(w);
        for (b = 0; b < int'(op.len); b++)
        begin
            d = $urandom;
            be = op.partial ? mem_bus_pkg::mem_be_t'($urandom) : '1;
            a = mem_bus_pkg::mem_addr_t'(op.addr + b);
            for (int i = 0; i < mem_bus_pkg::be_width; i++)
            begin
                if (be[i])
                    shadow[a][8*i +: 8] = d[8*i +: 8];
            end
            wr_valid = 1'b1;
            wr_req = '0;
            wr_req.address = op.addr;
            wr_req.burstcount = op.len;
            wr_req.data = d;
            wr_req.byteenable = be;
            wr_req.user = op.user;
            t = 0;
            while (wr_waitrequest && t < wait_limit)
            begin
                @(posedge clk);
                #1;
                t++;
            end
            if (wr_waitrequest)
            begin
                timeout_errors++;
                $display("Write beat %0d at address %h was never accepted", b, op.addr);
            end
            else
            begin
                @(posedge clk);
                #1;
            end
        end
        wr_valid = 1'b0;
    endtask

    task automatic wait_idle();
        int t;
        t = 0;
        while ((exp_rd.size() != 0 || exp_wr.size() != 0) && t < wait_limit)
        begin
            @(posedge clk);
            #1;
            t++;
        end
        if (exp_rd.size() != 0 || exp_wr.size() != 0)
        begin
            timeout_errors++;
            $display("Responses still missing: %0d read beats, %0d write responses",
                     exp_rd.size(), exp_wr.size());
        end
    endtask

    initial
    begin
        void'($urandom(32'h8458ac8a));
        reset_n = 1'b0;
        rd_valid = 1'b0;
        rd_req = '0;
        wr_valid = 1'b0;
        wr_req = '0;
        value_errors = 0;
        timeout_errors = 0;
        rd_beats_seen = 0;
        wr_rsps_seen = 0;
        exp_rd_total = 0;
        exp_wr_total = 0;
        rd_stall_cycles = 0;
        for (int k = 0; k < num_ops; k++)
        begin
            if (ops[k].is_write)
                exp_wr_total++;
            else
                exp_rd_total += int'(ops[k].len);
        end

        repeat (4) @(posedge clk);
        #1;
        reset_n = 1'b1;

        // Quiet bus before the first request, both queues empty
        repeat (3)
        begin
            @(negedge clk);
            check_bit("rd_rsp_valid", rd_rsp_valid, 1'b0);
            check_bit("wr_rsp_valid", wr_rsp_valid, 1'b0);
            check_bit("rd_waitrequest", rd_waitrequest, 1'b0);
            check_bit("wr_waitrequest", wr_waitrequest, 1'b0);
        end
        @(posedge clk);
        #1;

        // A group runs its reads and writes on both channels at once
        idx = 0;
        while (idx < num_ops)
        begin
            first = idx;
            while (ops[idx].with_next && idx < num_ops - 1)
                idx++;
            fork
                for (int k = first; k <= idx; k++)
                begin
                    if (!ops[k].is_write)
                        issue_read(ops[k]);
                end
                for (int k = first; k <= idx; k++)
                begin
                    if (ops[k].is_write)
                        issue_write(ops[k]);
                end
            join
            wait_idle();
            idx++;
        end

        repeat (5) @(posedge clk);
        check_count("read beat total", rd_beats_seen, exp_rd_total);
        check_count("write response total", wr_rsps_seen, exp_wr_total);

        // The back-to-back read group overfills the two-entry read queue
        check_bit("rd_waitrequest", rd_stall_cycles != 0, 1'b1);

        $display("Error counts: value %0d, timeout %0d, assertion %0d",
                 value_errors, timeout_errors, uut.chk.fail_count);
        if (value_errors == 0 && timeout_errors == 0 && uut.chk.fail_count == 0)
            $display("Testbench passed");
        else
            $display("Testbench failed");
        $finish;
    end

endmodule

/* list.f */
logic/mem_bus_pkg.sv
logic/mem_msg_pkg.sv
logic/rdwr_req_queue.sv
logic/rdwr_arbiter.sv
logic/mem_sink_model.sv
logic/rdwr_mem_top.sv
test/rdwr_mem_chk.sv
test/rdwr_mem_tb.sv
